// ==== hw/sb_defs.svh ====
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// ------------------------------
// scoreboard sizing
// ------------------------------

// table depth, power of two so the pointers wrap on their own
`define SB_NR_ENTRIES 8

// commit ports towards the commit stage
`define SB_NR_COMMIT 2

// write-back ports from the functional units
`define SB_NR_WB 2

// integer register file, 32 registers
`define SB_REG_AW 5
`define SB_XLEN 32

// exception cause field
`define SB_CAUSE_W 4

`endif

// ==== hw/sb_pkg.sv ====
`default_nettype none

`include "sb_defs.svh"

package sb_pkg;

  // ------------------------------
  // functional units
  // ------------------------------

  // NONE means the entry completes without a write-back
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    ALU       = 3'd1,
    LOAD      = 3'd2,
    STORE     = 3'd3,
    MULT      = 3'd4,
    CTRL_FLOW = 3'd5
  } fu_t;

  // ------------------------------
  // basic words
  // ------------------------------

  // index into the table, doubles as the transaction id
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;
  typedef logic [`SB_REG_AW-1:0] reg_addr_t;
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // exception record from decode or from a functional unit
  typedef struct packed {
    logic                   valid;
    logic [`SB_CAUSE_W-1:0] cause;
  } exc_t;

  // one instruction record, 81 bits
  typedef struct packed {
    xlen_t     pc;
    trans_id_t trans_id;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    // set once the result is complete
    logic      valid;
    exc_t      ex;
  } sb_entry_t;

endpackage

`default_nettype wire

// ==== hw/sb_prio_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module sb_prio_select #(
  parameter int unsigned NUM_IN = 2,
  parameter type payload_t = logic
) (
  input  logic     [NUM_IN-1:0] req_i,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic                  valid_o,
  output payload_t              data_o
);

  // high once a request has been taken in the scan below
  logic found;

  // ------------------------------
  // lowest index wins
  // ------------------------------

  always_comb begin
    found  = 1'b0;
    // all zero payload when nobody requests
    data_o = payload_t'(0);
    for (int unsigned i = 0; i < NUM_IN; i++) begin
      // first active request in index order, later ones are ignored
      if (req_i[i] && !found) begin
        found  = 1'b1;
        data_o = data_i[i];
      end
    end
  end

  // any active request gives a valid result
  assign valid_o = found;

endmodule

`default_nettype wire

// ==== hw/sb_entry_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sb_defs.svh"

module sb_entry_table (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            unresolved_branch_i,
  // decoded instruction from the decoder
  input  sb_pkg::sb_entry_t                               decoded_instr_i,
  input  logic                                            decoded_instr_valid_i,
  output logic                                            decoded_instr_ack_o,
  output logic                                            sb_full_o,
  // instruction towards the issue logic
  output sb_pkg::sb_entry_t                               issue_instr_o,
  output logic                                            issue_instr_valid_o,
  input  logic                                            issue_ack_i,
  // write-back ports
  input  logic              [`SB_NR_WB-1:0]               wt_valid_i,
  input  sb_pkg::trans_id_t [`SB_NR_WB-1:0]               trans_id_i,
  input  sb_pkg::xlen_t     [`SB_NR_WB-1:0]               wbdata_i,
  input  sb_pkg::exc_t      [`SB_NR_WB-1:0]               ex_i,
  // commit ports
  output sb_pkg::sb_entry_t [`SB_NR_COMMIT-1:0]           commit_instr_o,
  input  logic              [`SB_NR_COMMIT-1:0]           commit_ack_i,
  // full table view for clobber map and forwarding
  output sb_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0]          entries_o,
  output logic              [`SB_NR_ENTRIES-1:0]          issued_o
);

  import sb_pkg::*;

  localparam int unsigned N     = `SB_NR_ENTRIES;
  localparam int unsigned NCW   = $clog2(`SB_NR_COMMIT) + 1;

  // payload storage, flags live in the vectors below
  sb_entry_t [N-1:0] mem_q, mem_n;
  logic      [N-1:0] issued_q, issued_n;
  logic      [N-1:0] valid_q, valid_n;
  logic      [N-1:0] exv_q, exv_n;

  // merged view of payload and flags
  sb_entry_t [N-1:0] entries;

  trans_id_t issue_ptr_q, issue_ptr_n;
  trans_id_t commit_ptr_q, commit_ptr_n;
  trans_id_t issue_cnt_q, issue_cnt_n;
  trans_id_t [`SB_NR_COMMIT-1:0] commit_idx;

  logic           issue_full;
  logic           issue_en;
  logic [NCW-1:0] num_commit;

  // ------------------------------
  // issue side handshake
  // ------------------------------

  // seven entries occupied, one slot is kept free
  assign issue_full = &issue_cnt_q;
  assign sb_full_o  = issue_full;

  always_comb begin
    issue_instr_o          = decoded_instr_i;
    // the slot index becomes the transaction id
    issue_instr_o.trans_id = issue_ptr_q;
    issue_instr_valid_o    = decoded_instr_valid_i & ~unresolved_branch_i & ~issue_full;
    decoded_instr_ack_o    = issue_ack_i & ~issue_full;
  end

  assign issue_en = decoded_instr_valid_i & decoded_instr_ack_o;

  // ------------------------------
  // table view and commit ports
  // ------------------------------

  always_comb begin
    for (int unsigned i = 0; i < N; i++) begin
      entries[i]          = mem_q[i];
      entries[i].valid    = valid_q[i];
      entries[i].ex.valid = exv_q[i];
    end
  end

  assign entries_o = entries;
  assign issued_o  = issued_q;

  // commit port j looks at the slot j places after the head
  for (genvar j = 0; j < `SB_NR_COMMIT; j++) begin : gen_commit
    assign commit_idx[j] = commit_ptr_q + trans_id_t'(j);

    always_comb begin
      commit_instr_o[j]          = entries[commit_idx[j]];
      commit_instr_o[j].trans_id = commit_idx[j];
    end
  end

  // ------------------------------
  // next state of the entries
  // ------------------------------

  always_comb begin
    mem_n    = mem_q;
    issued_n = issued_q;
    valid_n  = valid_q;
    exv_n    = exv_q;

    // store the accepted instruction at the issue pointer
    if (issue_en) begin
      mem_n[issue_ptr_q]    = issue_instr_o;
      issued_n[issue_ptr_q] = 1'b1;
      valid_n[issue_ptr_q]  = decoded_instr_i.valid;
      exv_n[issue_ptr_q]    = decoded_instr_i.ex.valid;
    end

    // no functional unit, done one cycle after it was stored
    for (int unsigned i = 0; i < N; i++) begin
      if (issued_q[i] && mem_q[i].fu == NONE) begin
        valid_n[i] = 1'b1;
      end
    end

    // results from the functional units
    for (int unsigned k = 0; k < `SB_NR_WB; k++) begin
      // stale write-backs after a flush hit non-issued slots and are dropped
      if (wt_valid_i[k] && issued_q[trans_id_i[k]]) begin
        valid_n[trans_id_i[k]]      = 1'b1;
        mem_n[trans_id_i[k]].result = wbdata_i[k];
        if (ex_i[k].valid) begin
          mem_n[trans_id_i[k]].ex = ex_i[k];
          exv_n[trans_id_i[k]]    = 1'b1;
        end
      end
    end

    // retired entries leave the table
    for (int unsigned j = 0; j < `SB_NR_COMMIT; j++) begin
      if (commit_ack_i[j]) begin
        issued_n[commit_idx[j]] = 1'b0;
        valid_n[commit_idx[j]]  = 1'b0;
      end
    end

    // flush wins over everything above
    if (flush_i) begin
      issued_n = '0;
      valid_n  = '0;
      exv_n    = '0;
    end
  end

  // ------------------------------
  // pointers and occupancy
  // ------------------------------

  // number of entries retired this cycle
  always_comb begin
    num_commit = '0;
    for (int unsigned j = 0; j < `SB_NR_COMMIT; j++) begin
      num_commit = num_commit + NCW'(commit_ack_i[j]);
    end
  end

  assign issue_cnt_n  = flush_i ? '0 :
                        issue_cnt_q - trans_id_t'(num_commit) + trans_id_t'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + trans_id_t'(num_commit);
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      exv_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
    end else begin
      issued_q     <= issued_n;
      valid_q      <= valid_n;
      exv_q        <= exv_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      issue_cnt_q  <= issue_cnt_n;
    end
  end

  // payload only, meaningless while the issued flag is low
  always_ff @(posedge clk_i) begin
    mem_q <= mem_n;
  end

endmodule

`default_nettype wire

// ==== hw/sb_clobber_map.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sb_defs.svh"

module sb_clobber_map (
  input  sb_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0]  entries_i,
  input  logic              [`SB_NR_ENTRIES-1:0]  issued_i,
  output sb_pkg::fu_t       [2**`SB_REG_AW-1:0]   rd_clobber_o
);

  import sb_pkg::*;

  localparam int unsigned N       = `SB_NR_ENTRIES;
  localparam int unsigned NR_REGS = 2**`SB_REG_AW;

  // one request row per register, the extra top bit is the default
  logic [NR_REGS-1:0][N:0] clobber_req;
  fu_t  [N:0]              clobber_fu;

  // ------------------------------
  // requests per register
  // ------------------------------

  always_comb begin
    clobber_req = '0;
    // lowest priority slot carries NONE
    clobber_fu[N] = NONE;
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      clobber_req[r][N] = 1'b1;
    end
    // every issued entry claims its destination register
    for (int unsigned i = 0; i < N; i++) begin
      clobber_fu[i] = entries_i[i].fu;
      clobber_req[entries_i[i].rd][i] = issued_i[i];
    end
    // x0 is never written, idle selector output is NONE
    clobber_req[0] = '0;
  end

  // ------------------------------
  // one selector per register
  // ------------------------------

  for (genvar r = 0; r < NR_REGS; r++) begin : gen_clobber
    sb_prio_select #(
      .NUM_IN    (N + 1),
      .payload_t (fu_t)
    ) u_sel (
      .req_i   (clobber_req[r]),
      .data_i  (clobber_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[r])
    );
  end

endmodule

`default_nettype wire

// ==== hw/sb_operand_fwd.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sb_defs.svh"

module sb_operand_fwd (
  input  sb_pkg::reg_addr_t                         rs1_i,
  input  sb_pkg::reg_addr_t                         rs2_i,
  input  sb_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0]    entries_i,
  input  logic              [`SB_NR_ENTRIES-1:0]    issued_i,
  input  logic              [`SB_NR_WB-1:0]         wt_valid_i,
  input  sb_pkg::trans_id_t [`SB_NR_WB-1:0]         trans_id_i,
  input  sb_pkg::xlen_t     [`SB_NR_WB-1:0]         wbdata_i,
  input  sb_pkg::exc_t      [`SB_NR_WB-1:0]         ex_i,
  output sb_pkg::xlen_t                             rs1_o,
  output sb_pkg::xlen_t                             rs2_o,
  output logic                                      rs1_valid_o,
  output logic                                      rs2_valid_o
);

  import sb_pkg::*;

  localparam int unsigned N      = `SB_NR_ENTRIES;
  localparam int unsigned NR_WB  = `SB_NR_WB;
  localparam int unsigned NR_REQ = NR_WB + N;

  // write-back ports sit at the low indices and so win
  logic      [NR_REQ-1:0] rs1_req, rs2_req;
  xlen_t     [NR_REQ-1:0] fwd_data;
  reg_addr_t [NR_WB-1:0]  wb_rd;
  logic                   rs1_hit, rs2_hit;

  // ------------------------------
  // write-back port requests
  // ------------------------------

  for (genvar k = 0; k < NR_WB; k++) begin : gen_wb
    // destination of the entry being written back
    assign wb_rd[k]    = entries_i[trans_id_i[k]].rd;
    // a faulting result is never forwarded
    assign rs1_req[k]  = wt_valid_i[k] & ~ex_i[k].valid & (wb_rd[k] == rs1_i);
    assign rs2_req[k]  = wt_valid_i[k] & ~ex_i[k].valid & (wb_rd[k] == rs2_i);
    assign fwd_data[k] = wbdata_i[k];
  end

  // ------------------------------
  // completed entry requests
  // ------------------------------

  for (genvar i = 0; i < N; i++) begin : gen_entry
    assign rs1_req[NR_WB+i]  = issued_i[i] & entries_i[i].valid & (entries_i[i].rd == rs1_i);
    assign rs2_req[NR_WB+i]  = issued_i[i] & entries_i[i].valid & (entries_i[i].rd == rs2_i);
    assign fwd_data[NR_WB+i] = entries_i[i].result;
  end

  sb_prio_select #(
    .NUM_IN    (NR_REQ),
    .payload_t (xlen_t)
  ) u_sel_rs1 (
    .req_i   (rs1_req),
    .data_i  (fwd_data),
    .valid_o (rs1_hit),
    .data_o  (rs1_o)
  );

  sb_prio_select #(
    .NUM_IN    (NR_REQ),
    .payload_t (xlen_t)
  ) u_sel_rs2 (
    .req_i   (rs2_req),
    .data_i  (fwd_data),
    .valid_o (rs2_hit),
    .data_o  (rs2_o)
  );

  // x0 reads as zero from the register file, never forwarded
  assign rs1_valid_o = rs1_hit & (|rs1_i);
  assign rs2_valid_o = rs2_hit & (|rs2_i);

endmodule

`default_nettype wire

// ==== hw/scoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sb_defs.svh"

module scoreboard (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            unresolved_branch_i,
  output logic                                            sb_full_o,
  // functional unit about to write each integer register
  output sb_pkg::fu_t       [2**`SB_REG_AW-1:0]           rd_clobber_o,
  // operand read, same view as the register file
  input  sb_pkg::reg_addr_t                               rs1_i,
  output sb_pkg::xlen_t                                   rs1_o,
  output logic                                            rs1_valid_o,
  input  sb_pkg::reg_addr_t                               rs2_i,
  output sb_pkg::xlen_t                                   rs2_o,
  output logic                                            rs2_valid_o,
  // two oldest entries towards commit
  output sb_pkg::sb_entry_t [`SB_NR_COMMIT-1:0]           commit_instr_o,
  input  logic              [`SB_NR_COMMIT-1:0]           commit_ack_i,
  // decoder side
  input  sb_pkg::sb_entry_t                               decoded_instr_i,
  input  logic                                            decoded_instr_valid_i,
  output logic                                            decoded_instr_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                               issue_instr_o,
  output logic                                            issue_instr_valid_o,
  input  logic                                            issue_ack_i,
  // write-back ports
  input  sb_pkg::trans_id_t [`SB_NR_WB-1:0]               trans_id_i,
  input  sb_pkg::xlen_t     [`SB_NR_WB-1:0]               wbdata_i,
  input  sb_pkg::exc_t      [`SB_NR_WB-1:0]               ex_i,
  input  logic              [`SB_NR_WB-1:0]               wt_valid_i
);

  import sb_pkg::*;

  // registered table contents shared by clobber map and forwarding
  sb_entry_t [`SB_NR_ENTRIES-1:0] entries;
  logic      [`SB_NR_ENTRIES-1:0] issued;

  // ------------------------------
  // entry storage
  // ------------------------------

  sb_entry_table u_entry_table (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .wt_valid_i            (wt_valid_i),
    .trans_id_i            (trans_id_i),
    .wbdata_i              (wbdata_i),
    .ex_i                  (ex_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .entries_o             (entries),
    .issued_o              (issued)
  );

  // ------------------------------
  // destination tracking
  // ------------------------------

  sb_clobber_map u_clobber_map (
    .entries_i    (entries),
    .issued_i     (issued),
    .rd_clobber_o (rd_clobber_o)
  );

  // ------------------------------
  // operand forwarding
  // ------------------------------

  // write-back ports feed in the same cycle, stored results after that
  sb_operand_fwd u_operand_fwd (
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .entries_i   (entries),
    .issued_i    (issued),
    .wt_valid_i  (wt_valid_i),
    .trans_id_i  (trans_id_i),
    .wbdata_i    (wbdata_i),
    .ex_i        (ex_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_scoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sb_defs.svh"

module tb_scoreboard;

  import sb_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned DRIVE_SKEW = 2;
  localparam logic [31:0] SEED       = 32'h7e55c89e;
  localparam int unsigned TIMEOUT    = 200;
  localparam int unsigned N          = `SB_NR_ENTRIES;
  localparam int unsigned NR_REGS    = 2**`SB_REG_AW;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic                           clk_i, rst_ni, flush_i, unresolved_branch_i;
  logic                           sb_full_o;
  fu_t       [NR_REGS-1:0]        rd_clobber_o;
  reg_addr_t                      rs1_i, rs2_i;
  xlen_t                          rs1_o, rs2_o;
  logic                           rs1_valid_o, rs2_valid_o;
  sb_entry_t [`SB_NR_COMMIT-1:0]  commit_instr_o;
  logic      [`SB_NR_COMMIT-1:0]  commit_ack_i;
  sb_entry_t                      decoded_instr_i, issue_instr_o;
  logic                           decoded_instr_valid_i, decoded_instr_ack_o;
  logic                           issue_instr_valid_o, issue_ack_i;
  trans_id_t [`SB_NR_WB-1:0]      trans_id_i;
  xlen_t     [`SB_NR_WB-1:0]      wbdata_i;
  exc_t      [`SB_NR_WB-1:0]      ex_i;
  logic      [`SB_NR_WB-1:0]      wt_valid_i;

  // reference model of the table
  sb_entry_t    m_mem [N];
  logic [N-1:0] m_iss, m_val, m_exv;
  trans_id_t    m_iptr, m_cptr, m_cnt;
  // decoder keeps an unaccepted instruction for the next cycle
  logic         held;

  // traffic mix of the current phase
  logic         issue_on, commit_on, flush_on, force_flush;
  logic [31:0]  lfsr;
  int unsigned  entry_errs, fu_errs, word_errs, bit_errs, other_errs;
  int unsigned  full_seen, dual_seen, flush_seen;

  scoreboard u_scoreboard (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .sb_full_o             (sb_full_o),
    .rd_clobber_o          (rd_clobber_o),
    .rs1_i                 (rs1_i),
    .rs1_o                 (rs1_o),
    .rs1_valid_o           (rs1_valid_o),
    .rs2_i                 (rs2_i),
    .rs2_o                 (rs2_o),
    .rs2_valid_o           (rs2_valid_o),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .issue_ack_i           (issue_ack_i),
    .trans_id_i            (trans_id_i),
    .wbdata_i              (wbdata_i),
    .ex_i                  (ex_i),
    .wt_valid_i            (wt_valid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // ------------------------------
  // random numbers
  // ------------------------------

  // right shifting galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_entry(input string name, input sb_entry_t exp, input sb_entry_t act);
    if (act !== exp) begin
      entry_errs++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_fu(input string name, input fu_t exp, input fu_t act);
    if (act !== exp) begin
      fu_errs++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      word_errs++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  // state update for the inputs seen at this clock edge
  task automatic model_advance();
    sb_entry_t    nm [N];
    logic [N-1:0] niss, nval, nexv;
    logic         accept;
    trans_id_t    ncommit;
    trans_id_t    idx;
    nm      = m_mem;
    niss    = m_iss;
    nval    = m_val;
    nexv    = m_exv;
    ncommit = '0;
    accept  = decoded_instr_valid_i && issue_ack_i && (m_cnt != trans_id_t'(N - 1));
    if (accept) begin
      nm[m_iptr]          = decoded_instr_i;
      nm[m_iptr].trans_id = m_iptr;
      niss[m_iptr]        = 1'b1;
      nval[m_iptr]        = decoded_instr_i.valid;
      nexv[m_iptr]        = decoded_instr_i.ex.valid;
    end
    // entries without a unit finish on their own
    for (int i = 0; i < N; i++) begin
      if (m_iss[i] && m_mem[i].fu == NONE) begin
        nval[i] = 1'b1;
      end
    end
    for (int k = 0; k < `SB_NR_WB; k++) begin
      if (wt_valid_i[k] && m_iss[trans_id_i[k]]) begin
        nval[trans_id_i[k]]      = 1'b1;
        nm[trans_id_i[k]].result = wbdata_i[k];
        if (ex_i[k].valid) begin
          nm[trans_id_i[k]].ex = ex_i[k];
          nexv[trans_id_i[k]]  = 1'b1;
        end
      end
    end
    for (int j = 0; j < `SB_NR_COMMIT; j++) begin
      idx = trans_id_t'(m_cptr + j);
      if (commit_ack_i[j]) begin
        niss[idx] = 1'b0;
        nval[idx] = 1'b0;
        ncommit   = ncommit + 1'b1;
      end
    end
    held  = decoded_instr_valid_i && !accept;
    m_mem = nm;
    if (flush_i) begin
      m_iss  = '0;
      m_val  = '0;
      m_exv  = '0;
      m_iptr = '0;
      m_cptr = '0;
      m_cnt  = '0;
    end else begin
      m_iss  = niss;
      m_val  = nval;
      m_exv  = nexv;
      m_iptr = m_iptr + trans_id_t'(accept);
      m_cptr = m_cptr + ncommit;
      m_cnt  = m_cnt - ncommit + trans_id_t'(accept);
    end
  endtask

  // write-back ports beat stored results, lowest index wins in each group
  task automatic fwd_expect(input reg_addr_t rs, output logic hit, output xlen_t data);
    hit  = 1'b0;
    data = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (m_iss[i] && m_val[i] && m_mem[i].rd == rs) begin
        hit  = 1'b1;
        data = m_mem[i].result;
      end
    end
    for (int k = `SB_NR_WB - 1; k >= 0; k--) begin
      if (wt_valid_i[k] && !ex_i[k].valid && m_mem[trans_id_i[k]].rd == rs) begin
        hit  = 1'b1;
        data = wbdata_i[k];
      end
    end
    hit = hit && (rs != '0);
  endtask

  // ------------------------------
  // stimulus and checks
  // ------------------------------

  task automatic drive_inputs();
    trans_id_t pick;
    flush_i = force_flush || (flush_on && rand_bits(6) == 0);
    if (flush_i) begin
      flush_seen++;
    end
    unresolved_branch_i = (rand_bits(3) == 0);
    issue_ack_i         = (rand_bits(2) != 0);
    if (!issue_on) begin
      decoded_instr_valid_i = 1'b0;
    end else if (!held) begin
      decoded_instr_valid_i    = (rand_bits(2) != 0);
      decoded_instr_i          = '0;
      decoded_instr_i.pc       = rand_bits(32);
      decoded_instr_i.trans_id = trans_id_t'(rand_bits(3));
      decoded_instr_i.fu       = fu_t'(3'(rand_bits(3) % 6));
      decoded_instr_i.rd       = reg_addr_t'(rand_bits(5));
      decoded_instr_i.result   = rand_bits(32);
      // some instructions arrive already complete from decode
      decoded_instr_i.valid    = (rand_bits(3) == 0);
      decoded_instr_i.ex.valid = (rand_bits(4) == 0);
      decoded_instr_i.ex.cause = 4'(rand_bits(4));
    end
    // half the reads aim at a destination held in the table
    rs1_i = (rand_bits(1) != 0) ? m_mem[trans_id_t'(rand_bits(3))].rd : reg_addr_t'(rand_bits(5));
    rs2_i = (rand_bits(1) != 0) ? m_mem[trans_id_t'(rand_bits(3))].rd : reg_addr_t'(rand_bits(5));
    // results only for issued entries that still wait for a unit
    for (int k = 0; k < `SB_NR_WB; k++) begin
      pick          = trans_id_t'(rand_bits(3));
      wt_valid_i[k] = m_iss[pick] && !m_val[pick] && m_mem[pick].fu != NONE &&
                      (rand_bits(1) != 0);
      for (int p = 0; p < k; p++) begin
        if (wt_valid_i[p] && trans_id_i[p] == pick) begin
          wt_valid_i[k] = 1'b0;
        end
      end
      trans_id_i[k]  = pick;
      wbdata_i[k]    = rand_bits(32);
      ex_i[k].valid  = (rand_bits(4) == 0);
      ex_i[k].cause  = 4'(rand_bits(4));
    end
    commit_ack_i = '0;
    if (commit_on && m_val[m_cptr] && rand_bits(1) != 0) begin
      commit_ack_i[0] = 1'b1;
      if (m_val[trans_id_t'(m_cptr + 1)] && rand_bits(1) != 0) begin
        commit_ack_i[1] = 1'b1;
        dual_seen++;
      end
    end
  endtask

  task automatic check_outputs();
    logic      exp_full;
    sb_entry_t exp;
    trans_id_t idx;
    fu_t       exp_fu;
    logic      hit;
    xlen_t     data;
    exp_full = (m_cnt == trans_id_t'(N - 1));
    if (exp_full) begin
      full_seen++;
    end
    check_bit("sb_full_o", exp_full, sb_full_o);
    check_bit("decoded_instr_ack_o", issue_ack_i & ~exp_full, decoded_instr_ack_o);
    check_bit("issue_instr_valid_o", decoded_instr_valid_i & ~unresolved_branch_i & ~exp_full,
              issue_instr_valid_o);
    exp          = decoded_instr_i;
    exp.trans_id = m_iptr;
    check_entry("issue_instr_o", exp, issue_instr_o);
    // payload of a free slot is undefined, only its valid bit counts
    for (int j = 0; j < `SB_NR_COMMIT; j++) begin
      idx = trans_id_t'(m_cptr + j);
      if (m_iss[idx]) begin
        exp          = m_mem[idx];
        exp.trans_id = idx;
        exp.valid    = m_val[idx];
        exp.ex.valid = m_exv[idx];
        check_entry($sformatf("commit_instr_o[%0d]", j), exp, commit_instr_o[j]);
      end else begin
        check_bit($sformatf("commit_instr_o[%0d].valid", j), 1'b0, commit_instr_o[j].valid);
      end
    end
    for (int r = 0; r < NR_REGS; r++) begin
      exp_fu = NONE;
      for (int i = N - 1; i >= 0; i--) begin
        if (r != 0 && m_iss[i] && m_mem[i].rd == reg_addr_t'(r)) begin
          exp_fu = m_mem[i].fu;
        end
      end
      check_fu($sformatf("rd_clobber_o[%0d]", r), exp_fu, rd_clobber_o[r]);
    end
    fwd_expect(rs1_i, hit, data);
    check_bit("rs1_valid_o", hit, rs1_valid_o);
    if (hit) begin
      check_word("rs1_o", data, rs1_o);
    end
    fwd_expect(rs2_i, hit, data);
    check_bit("rs2_valid_o", hit, rs2_valid_o);
    if (hit) begin
      check_word("rs2_o", data, rs2_o);
    end
  endtask

  // one clock: model follows the edge, new inputs, then compare mid cycle
  task automatic step();
    @(posedge clk_i);
    model_advance();
    #(DRIVE_SKEW);
    drive_inputs();
    #(CLK_PERIOD / 2);
    check_outputs();
  endtask

  task automatic wait_full();
    int unsigned n;
    n = 0;
    while (!sb_full_o && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!sb_full_o) begin
      other_errs++;
      $display("table did not become full within %0d cycles", TIMEOUT);
    end
  endtask

  task automatic wait_empty();
    int unsigned n;
    n = 0;
    while (m_cnt != '0 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (m_cnt != '0) begin
      other_errs++;
      $display("table did not drain within %0d cycles", TIMEOUT);
    end
  endtask

  task automatic finish_run();
    $display("errors entry %0d fu %0d word %0d bit %0d other %0d",
             entry_errs, fu_errs, word_errs, bit_errs, other_errs);
    if (entry_errs + fu_errs + word_errs + bit_errs + other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    unresolved_branch_i   = 1'b0;
    rs1_i                 = '0;
    rs2_i                 = '0;
    commit_ack_i          = '0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    trans_id_i            = '0;
    wbdata_i              = '0;
    ex_i                  = '0;
    wt_valid_i            = '0;
    for (int i = 0; i < N; i++) begin
      m_mem[i] = '0;
    end
    {m_iss, m_val, m_exv} = '0;
    {m_iptr, m_cptr, m_cnt} = '0;
    {held, issue_on, commit_on, flush_on, force_flush} = '0;
    {entry_errs, fu_errs, word_errs, bit_errs, other_errs} = '0;
    {full_seen, dual_seen, flush_seen} = '0;
    lfsr = SEED;
    repeat (10) @(posedge clk_i);
    #(DRIVE_SKEW);
    rst_ni = 1'b1;
    #(CLK_PERIOD / 2);
    // idle state right after reset
    check_outputs();
    // mixed traffic with rare flushes
    {issue_on, commit_on, flush_on} = 3'b111;
    repeat (1500) step();
    // commits held back until the table fills
    {commit_on, flush_on} = 2'b00;
    wait_full();
    if (other_errs == 0) begin
      repeat (4) step();
      {issue_on, commit_on} = 2'b01;
      wait_empty();
    end
    // flush with entries in flight, ids restart at zero
    if (other_errs == 0) begin
      {issue_on, commit_on} = 2'b10;
      repeat (6) step();
      force_flush = 1'b1;
      step();
      force_flush = 1'b0;
      repeat (6) step();
    end
    if (full_seen == 0 || dual_seen == 0 || flush_seen == 0) begin
      other_errs++;
      $display("stimulus never reached a full table, a dual commit or a flush");
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/sb_pkg.sv
hw/sb_prio_select.sv
hw/sb_entry_table.sv
hw/sb_clobber_map.sv
hw/sb_operand_fwd.sv
hw/scoreboard.sv
sim/tb_scoreboard.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0 --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/10ps
TOP        = tb_scoreboard
RTL_TOP    = scoreboard
FILELIST   = build.f
BIN        = obj_dir/V$(TOP)
PASS_MSG   = All checks passed
SRCS       = $(shell grep -v '^+' $(FILELIST)) hw/sb_defs.svh

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
